// ==== rtl/csr_pkg.sv ====
package csr_pkg;

    // -------------------------------------------------------------------------
    // addresses
    // -------------------------------------------------------------------------
    typedef logic [11:0] csr_addr_t;

    // machine information registers
    localparam csr_addr_t CSR_MVENDORID  = 12'hF11;
    localparam csr_addr_t CSR_MARCHID    = 12'hF12;
    localparam csr_addr_t CSR_MIMPID     = 12'hF13;
    localparam csr_addr_t CSR_MCONFIGPTR = 12'hF15;

    // trap setup
    localparam csr_addr_t CSR_MSTATUS    = 12'h300;
    localparam csr_addr_t CSR_MISA       = 12'h301;
    localparam csr_addr_t CSR_MIE        = 12'h304;
    localparam csr_addr_t CSR_MTVEC      = 12'h305;

    // trap handling
    localparam csr_addr_t CSR_MSCRATCH   = 12'h340;
    localparam csr_addr_t CSR_MEPC       = 12'h341;
    localparam csr_addr_t CSR_MCAUSE     = 12'h342;
    localparam csr_addr_t CSR_MTVAL      = 12'h343;
    localparam csr_addr_t CSR_MIP        = 12'h344;

    // -------------------------------------------------------------------------
    // access opcodes
    // -------------------------------------------------------------------------
    // 100 and 110 are left over and decode as no access
    typedef enum logic [2:0] {
        OP_NONE  = 3'b000,
        OP_WRITE = 3'b001,
        OP_SET   = 3'b010,
        OP_CLEAR = 3'b011,
        OP_READ  = 3'b101,
        OP_MRET  = 3'b111
    } csr_op_e;

    // decoded access for one cycle
    typedef struct packed {
        csr_addr_t addr;
        logic      wr_en;
        logic      rd_en;
        logic      mret;
    } csr_access_t;

    // -------------------------------------------------------------------------
    // bit positions
    // -------------------------------------------------------------------------
    localparam int MSTATUS_MIE  = 3;
    localparam int MSTATUS_MPIE = 7;
    // low bit of the two bit mpp field
    localparam int MSTATUS_MPP  = 11;

    // same positions in mie and mip
    localparam int IRQ_MTI = 7;
    localparam int IRQ_MEI = 11;

    // vectored mtvec base is cleared below this bit
    localparam int MTVEC_VEC_ALIGN = 8;

    // misa extension bits A C I M
    localparam logic [25:0] MISA_EXT = 26'h0001105;

endpackage

// ==== rtl/trap_pkg.sv ====
package trap_pkg;

    // mcause code field in the low four bits
    typedef enum logic [3:0] {
        INST_MISALIGNED  = 4'd0,
        ILLEGAL_INST     = 4'd2,
        LOAD_MISALIGNED  = 4'd4,
        STORE_MISALIGNED = 4'd6,
        M_TIMER          = 4'd7,
        ECALL_M          = 4'd11
    } cause_e;

    // external irq shares code 11 with ecall
    // the irq flag in mcause keeps them apart
    localparam cause_e M_EXT = ECALL_M;

    // synchronous exception requests from the pipeline
    typedef struct packed {
        logic illegal;
        logic inst_mis;
        logic ecall_m;
        logic load_mis;
        logic store_mis;
    } exc_flags_t;

    // winning trap of the cycle
    typedef struct packed {
        logic   valid;
        logic   is_irq;
        cause_e code;
        logic   set_tval;
    } trap_event_t;

    // only machine mode exists
    localparam logic [1:0] PRIV_M = 2'b11;

endpackage

// ==== rtl/csr_op_decode.sv ====
module csr_op_decode #(
    parameter int XLEN = 64
) (
    input  csr_pkg::csr_addr_t   i_riscv_csr_address,
    input  csr_pkg::csr_op_e     i_riscv_csr_op,
    input  logic [XLEN-1:0]      i_riscv_csr_wdata,
    input  logic [XLEN-1:0]      i_cur_rdata,
    output csr_pkg::csr_access_t o_access,
    output logic [XLEN-1:0]      o_wr_value
);

    // opcode to access controls
    always_comb begin
        o_access      = '0;
        o_access.addr = i_riscv_csr_address;
        case (i_riscv_csr_op)
            csr_pkg::OP_WRITE,
            csr_pkg::OP_SET,
            csr_pkg::OP_CLEAR: begin
                // old value comes back on every write form
                o_access.wr_en = 1'b1;
                o_access.rd_en = 1'b1;
            end
            csr_pkg::OP_READ: o_access.rd_en = 1'b1;
            csr_pkg::OP_MRET: o_access.mret = 1'b1;
            default: ;
        endcase
        // a return never writes a register
        assert (!(o_access.wr_en && o_access.mret));
    end

    // merged write value
    // set and clear work on the current read value
    always_comb begin
        case (i_riscv_csr_op)
            csr_pkg::OP_SET:   o_wr_value = i_cur_rdata | i_riscv_csr_wdata;
            csr_pkg::OP_CLEAR: o_wr_value = i_cur_rdata & ~i_riscv_csr_wdata;
            default:           o_wr_value = i_riscv_csr_wdata;
        endcase
    end

endmodule

// ==== rtl/trap_arbiter.sv ====
module trap_arbiter (
    input  trap_pkg::exc_flags_t  i_exc,
    input  logic                  i_mstatus_mie,
    input  logic                  i_mie_mtie,
    input  logic                  i_mie_meie,
    input  logic                  i_mip_mtip,
    input  logic                  i_mip_meip,
    output trap_pkg::trap_event_t o_event
);

    logic ext_irq;
    logic tmr_irq;

    // global enable and local enable and pending all needed
    assign ext_irq = i_mstatus_mie & i_mie_meie & i_mip_meip;
    assign tmr_irq = i_mstatus_mie & i_mie_mtie & i_mip_mtip;

    // -------------------------------------------------------------------------
    // fixed priority pick
    // -------------------------------------------------------------------------
    always_comb begin
        o_event       = '0;
        o_event.valid = 1'b1;
        if (ext_irq) begin
            o_event.is_irq = 1'b1;
            o_event.code   = trap_pkg::M_EXT;
        end else if (tmr_irq) begin
            o_event.is_irq = 1'b1;
            o_event.code   = trap_pkg::M_TIMER;
        end else if (i_exc.illegal) begin
            o_event.code = trap_pkg::ILLEGAL_INST;
        end else if (i_exc.inst_mis) begin
            o_event.code = trap_pkg::INST_MISALIGNED;
        end else if (i_exc.ecall_m) begin
            o_event.code = trap_pkg::ECALL_M;
        end else if (i_exc.load_mis) begin
            // faulting address goes to mtval
            o_event.code     = trap_pkg::LOAD_MISALIGNED;
            o_event.set_tval = 1'b1;
        end else if (i_exc.store_mis) begin
            o_event.code     = trap_pkg::STORE_MISALIGNED;
            o_event.set_tval = 1'b1;
        end else begin
            // nothing pending this cycle
            o_event.valid = 1'b0;
        end
        // idle event carries no cause
        assert (o_event.valid || (o_event.code == trap_pkg::INST_MISALIGNED));
    end

endmodule

// ==== rtl/csr_regs.sv ====
module csr_regs #(
    parameter int XLEN = 64
) (
    input  logic                  i_riscv_csr_clk,
    input  logic                  i_riscv_csr_rst,
    input  csr_pkg::csr_access_t  i_access,
    input  logic [XLEN-1:0]       i_wr_value,
    input  trap_pkg::trap_event_t i_event,
    input  logic [XLEN-1:0]       i_pc,
    input  logic [XLEN-1:0]       i_alu_addr,
    input  logic                  i_ext_int,
    input  logic                  i_timer_int,
    output logic                  o_mstatus_mie,
    output logic                  o_mstatus_mpie,
    output logic [1:0]            o_mstatus_mpp,
    output logic                  o_mie_mtie,
    output logic                  o_mie_meie,
    output logic                  o_mip_mtip,
    output logic                  o_mip_meip,
    output logic [XLEN-1:0]       o_mtvec,
    output logic [XLEN-1:0]       o_mscratch,
    output logic [XLEN-1:0]       o_mepc,
    output logic                  o_mcause_irq,
    output logic [3:0]            o_mcause_code,
    output logic [XLEN-1:0]       o_mtval,
    output logic                  o_trap_taken,
    output logic                  o_trap_return
);

    // mode in bit 0 and bit 1 reads zero
    // vectored base is aligned further
    function automatic logic [XLEN-1:0] mtvec_mask(input logic [XLEN-1:0] value);
        logic [XLEN-1:0] res;
        res    = value;
        res[1] = 1'b0;
        if (value[0]) begin
            res[csr_pkg::MTVEC_VEC_ALIGN-1:2] = '0;
        end
        return res;
    endfunction

    // -------------------------------------------------------------------------
    // state update
    // -------------------------------------------------------------------------
    // trap first then mret then the software write
    always_ff @(posedge i_riscv_csr_clk or posedge i_riscv_csr_rst) begin
        if (i_riscv_csr_rst) begin
            o_mstatus_mie  <= 1'b0;
            o_mstatus_mpie <= 1'b0;
            o_mstatus_mpp  <= 2'b00;
            o_mie_mtie     <= 1'b0;
            o_mie_meie     <= 1'b0;
            o_mip_mtip     <= 1'b0;
            o_mip_meip     <= 1'b0;
            o_mtvec        <= '0;
            o_mscratch     <= '0;
            o_mepc         <= '0;
            o_mcause_irq   <= 1'b0;
            o_mcause_code  <= 4'd0;
            o_mtval        <= '0;
            o_trap_taken   <= 1'b0;
            o_trap_return  <= 1'b0;
        end else begin
            // pending bits follow the lines
            o_mip_mtip    <= i_timer_int;
            o_mip_meip    <= i_ext_int;
            o_trap_taken  <= i_event.valid;
            o_trap_return <= i_access.mret & ~i_event.valid;

            if (i_event.valid) begin
                // trap entry
                o_mepc         <= i_pc;
                o_mstatus_mpie <= o_mstatus_mie;
                o_mstatus_mie  <= 1'b0;
                o_mstatus_mpp  <= trap_pkg::PRIV_M;
                o_mcause_irq   <= i_event.is_irq;
                o_mcause_code  <= i_event.code;
                if (i_event.set_tval) begin
                    o_mtval <= i_alu_addr;
                end
            end else if (i_access.mret) begin
                // return restores the enable
                o_mstatus_mie  <= o_mstatus_mpie;
                o_mstatus_mpie <= 1'b1;
                o_mstatus_mpp  <= trap_pkg::PRIV_M;
            end else if (i_access.wr_en) begin
                case (i_access.addr)
                    csr_pkg::CSR_MSTATUS: begin
                        o_mstatus_mie  <= i_wr_value[csr_pkg::MSTATUS_MIE];
                        o_mstatus_mpie <= i_wr_value[csr_pkg::MSTATUS_MPIE];
                        o_mstatus_mpp  <= i_wr_value[csr_pkg::MSTATUS_MPP +: 2];
                    end
                    csr_pkg::CSR_MIE: begin
                        o_mie_mtie <= i_wr_value[csr_pkg::IRQ_MTI];
                        o_mie_meie <= i_wr_value[csr_pkg::IRQ_MEI];
                    end
                    csr_pkg::CSR_MTVEC:    o_mtvec    <= mtvec_mask(i_wr_value);
                    csr_pkg::CSR_MSCRATCH: o_mscratch <= i_wr_value;
                    // instructions are at least halfword aligned
                    csr_pkg::CSR_MEPC:     o_mepc     <= {i_wr_value[XLEN-1:1], 1'b0};
                    csr_pkg::CSR_MCAUSE: begin
                        o_mcause_irq  <= i_wr_value[XLEN-1];
                        o_mcause_code <= i_wr_value[3:0];
                    end
                    csr_pkg::CSR_MTVAL:    o_mtval    <= i_wr_value;
                    // mip and read only registers drop the write
                    default: ;
                endcase
            end
        end
    end

    // -------------------------------------------------------------------------
    // checks
    // -------------------------------------------------------------------------
    // entry and return never share a cycle
    a_pulse_excl: assert property (@(posedge i_riscv_csr_clk) disable iff (i_riscv_csr_rst)
        !(o_trap_taken && o_trap_return));

endmodule

// ==== rtl/csr_read_mux.sv ====
module csr_read_mux #(
    parameter int XLEN = 64
) (
    input  csr_pkg::csr_access_t i_access,
    input  logic                 i_mstatus_mie,
    input  logic                 i_mstatus_mpie,
    input  logic [1:0]           i_mstatus_mpp,
    input  logic                 i_mie_mtie,
    input  logic                 i_mie_meie,
    input  logic                 i_mip_mtip,
    input  logic                 i_mip_meip,
    input  logic [XLEN-1:0]      i_mtvec,
    input  logic [XLEN-1:0]      i_mscratch,
    input  logic [XLEN-1:0]      i_mepc,
    input  logic                 i_mcause_irq,
    input  logic [3:0]           i_mcause_code,
    input  logic [XLEN-1:0]      i_mtval,
    output logic [XLEN-1:0]      o_rdata
);

    // mxl field is 2 for rv64 and 1 for rv32
    localparam logic [1:0] MXL = (XLEN == 64) ? 2'b10 : 2'b01;
    localparam logic [XLEN-1:0] MISA_VAL = {MXL, {(XLEN-28){1'b0}}, csr_pkg::MISA_EXT};

    always_comb begin
        o_rdata = '0;
        if (i_access.rd_en) begin
            case (i_access.addr)
                csr_pkg::CSR_MISA: o_rdata = MISA_VAL;
                // id registers not implemented
                csr_pkg::CSR_MVENDORID,
                csr_pkg::CSR_MARCHID,
                csr_pkg::CSR_MIMPID,
                csr_pkg::CSR_MCONFIGPTR: o_rdata = '0;
                csr_pkg::CSR_MSTATUS: begin
                    o_rdata[csr_pkg::MSTATUS_MIE]      = i_mstatus_mie;
                    o_rdata[csr_pkg::MSTATUS_MPIE]     = i_mstatus_mpie;
                    o_rdata[csr_pkg::MSTATUS_MPP +: 2] = i_mstatus_mpp;
                end
                csr_pkg::CSR_MIE: begin
                    o_rdata[csr_pkg::IRQ_MTI] = i_mie_mtie;
                    o_rdata[csr_pkg::IRQ_MEI] = i_mie_meie;
                end
                csr_pkg::CSR_MIP: begin
                    o_rdata[csr_pkg::IRQ_MTI] = i_mip_mtip;
                    o_rdata[csr_pkg::IRQ_MEI] = i_mip_meip;
                end
                csr_pkg::CSR_MTVEC:    o_rdata = i_mtvec;
                csr_pkg::CSR_MSCRATCH: o_rdata = i_mscratch;
                csr_pkg::CSR_MEPC:     o_rdata = i_mepc;
                csr_pkg::CSR_MCAUSE: begin
                    // interrupt flag on top
                    o_rdata[XLEN-1] = i_mcause_irq;
                    o_rdata[3:0]    = i_mcause_code;
                end
                csr_pkg::CSR_MTVAL:    o_rdata = i_mtval;
                // unimplemented address reads zero
                default: o_rdata = '0;
            endcase
        end
    end

endmodule

// ==== rtl/riscv_csr_top.sv ====
module riscv_csr_top #(
    parameter int XLEN = 64
) (
    input  logic               i_riscv_csr_clk,
    input  logic               i_riscv_csr_rst,
    input  csr_pkg::csr_addr_t i_riscv_csr_address,
    input  csr_pkg::csr_op_e   i_riscv_csr_op,
    input  logic [XLEN-1:0]    i_riscv_csr_wdata,
    input  logic               i_riscv_csr_external_int,
    input  logic               i_riscv_csr_timer_int,
    input  logic               i_riscv_csr_illegal_inst,
    input  logic               i_riscv_csr_ecall_m,
    input  logic               i_riscv_csr_inst_addr_misaligned,
    input  logic               i_riscv_csr_load_addr_misaligned,
    input  logic               i_riscv_csr_store_addr_misaligned,
    input  logic [XLEN-1:0]    i_riscv_csr_pc,
    input  logic [XLEN-1:0]    i_riscv_csr_alu_addr,
    output logic [XLEN-1:0]    o_riscv_csr_rdata,
    output logic [XLEN-1:0]    o_riscv_csr_return_address,
    output logic [XLEN-1:0]    o_riscv_csr_trap_address,
    output logic               o_riscv_csr_trap_taken,
    output logic               o_riscv_csr_trap_return
);

    csr_pkg::csr_access_t  access;
    logic [XLEN-1:0]       wr_value;
    trap_pkg::exc_flags_t  exc;
    trap_pkg::trap_event_t trap_ev;

    // register fields between regs, arbiter and read mux
    logic                  mstatus_mie;
    logic                  mstatus_mpie;
    logic [1:0]            mstatus_mpp;
    logic                  mie_mtie;
    logic                  mie_meie;
    logic                  mip_mtip;
    logic                  mip_meip;
    logic [XLEN-1:0]       mscratch;
    logic                  mcause_irq;
    logic [3:0]            mcause_code;
    logic [XLEN-1:0]       mtval;

    // exception request bundle
    assign exc.illegal   = i_riscv_csr_illegal_inst;
    assign exc.inst_mis  = i_riscv_csr_inst_addr_misaligned;
    assign exc.ecall_m   = i_riscv_csr_ecall_m;
    assign exc.load_mis  = i_riscv_csr_load_addr_misaligned;
    assign exc.store_mis = i_riscv_csr_store_addr_misaligned;

    csr_op_decode #(.XLEN(XLEN)) u_decode (
        .i_riscv_csr_address (i_riscv_csr_address),
        .i_riscv_csr_op      (i_riscv_csr_op),
        .i_riscv_csr_wdata   (i_riscv_csr_wdata),
        .i_cur_rdata         (o_riscv_csr_rdata),
        .o_access            (access),
        .o_wr_value          (wr_value)
    );

    trap_arbiter u_arbiter (
        .i_exc         (exc),
        .i_mstatus_mie (mstatus_mie),
        .i_mie_mtie    (mie_mtie),
        .i_mie_meie    (mie_meie),
        .i_mip_mtip    (mip_mtip),
        .i_mip_meip    (mip_meip),
        .o_event       (trap_ev)
    );

    // mepc and mtvec go straight out as return and trap targets
    csr_regs #(.XLEN(XLEN)) u_regs (
        .i_riscv_csr_clk (i_riscv_csr_clk),
        .i_riscv_csr_rst (i_riscv_csr_rst),
        .i_access        (access),
        .i_wr_value      (wr_value),
        .i_event         (trap_ev),
        .i_pc            (i_riscv_csr_pc),
        .i_alu_addr      (i_riscv_csr_alu_addr),
        .i_ext_int       (i_riscv_csr_external_int),
        .i_timer_int     (i_riscv_csr_timer_int),
        .o_mstatus_mie   (mstatus_mie),
        .o_mstatus_mpie  (mstatus_mpie),
        .o_mstatus_mpp   (mstatus_mpp),
        .o_mie_mtie      (mie_mtie),
        .o_mie_meie      (mie_meie),
        .o_mip_mtip      (mip_mtip),
        .o_mip_meip      (mip_meip),
        .o_mtvec         (o_riscv_csr_trap_address),
        .o_mscratch      (mscratch),
        .o_mepc          (o_riscv_csr_return_address),
        .o_mcause_irq    (mcause_irq),
        .o_mcause_code   (mcause_code),
        .o_mtval         (mtval),
        .o_trap_taken    (o_riscv_csr_trap_taken),
        .o_trap_return   (o_riscv_csr_trap_return)
    );

    csr_read_mux #(.XLEN(XLEN)) u_read_mux (
        .i_access       (access),
        .i_mstatus_mie  (mstatus_mie),
        .i_mstatus_mpie (mstatus_mpie),
        .i_mstatus_mpp  (mstatus_mpp),
        .i_mie_mtie     (mie_mtie),
        .i_mie_meie     (mie_meie),
        .i_mip_mtip     (mip_mtip),
        .i_mip_meip     (mip_meip),
        .i_mtvec        (o_riscv_csr_trap_address),
        .i_mscratch     (mscratch),
        .i_mepc         (o_riscv_csr_return_address),
        .i_mcause_irq   (mcause_irq),
        .i_mcause_code  (mcause_code),
        .i_mtval        (mtval),
        .o_rdata        (o_riscv_csr_rdata)
    );

endmodule

// ==== test/csr_vectors.svh ====
// columns are name, opcode, address, write data, {ext, timer} lines,
// {illegal, inst_mis, ecall_m, load_mis, store_mis}, pc, alu address,
// then expected rdata, trap_taken, trap_return, return address, trap address

// ---------------------------------------------------------------------------
// reset values
// ---------------------------------------------------------------------------
add_row("rst_mstatus", csr_pkg::OP_READ, csr_pkg::CSR_MSTATUS, '0, 2'b00, 5'b00000,
        '0, '0, '0, 1'b0, 1'b0, '0, '0);
add_row("rst_misa", csr_pkg::OP_READ, csr_pkg::CSR_MISA, '0, 2'b00, 5'b00000,
        '0, '0, MISA_EXP, 1'b0, 1'b0, '0, '0);
add_row("rst_mcause", csr_pkg::OP_READ, csr_pkg::CSR_MCAUSE, '0, 2'b00, 5'b00000,
        '0, '0, '0, 1'b0, 1'b0, '0, '0);
add_row("rst_mvendorid", csr_pkg::OP_READ, csr_pkg::CSR_MVENDORID, '0, 2'b00, 5'b00000,
        '0, '0, '0, 1'b0, 1'b0, '0, '0);
add_row("rst_marchid", csr_pkg::OP_READ, csr_pkg::CSR_MARCHID, '0, 2'b00, 5'b00000,
        '0, '0, '0, 1'b0, 1'b0, '0, '0);
add_row("rst_mimpid", csr_pkg::OP_READ, csr_pkg::CSR_MIMPID, '0, 2'b00, 5'b00000,
        '0, '0, '0, 1'b0, 1'b0, '0, '0);
add_row("rst_mconfigptr", csr_pkg::OP_READ, csr_pkg::CSR_MCONFIGPTR, '0, 2'b00, 5'b00000,
        '0, '0, '0, 1'b0, 1'b0, '0, '0);

// ---------------------------------------------------------------------------
// write and read-back with the old value back on each write
// ---------------------------------------------------------------------------
add_row("wr_scratch", csr_pkg::OP_WRITE, csr_pkg::CSR_MSCRATCH, scr_v, 2'b00, 5'b00000,
        '0, '0, '0, 1'b0, 1'b0, '0, '0);
add_row("wr_mepc", csr_pkg::OP_WRITE, csr_pkg::CSR_MEPC, epc_raw, 2'b00, 5'b00000,
        '0, '0, '0, 1'b0, 1'b0, epc_v, '0);
add_row("wr_mtvec", csr_pkg::OP_WRITE, csr_pkg::CSR_MTVEC, tvec_raw, 2'b00, 5'b00000,
        '0, '0, '0, 1'b0, 1'b0, epc_v, tvec_v);
// mip follows the lines one cycle late and drops the write of zero
add_row("wr_mip", csr_pkg::OP_WRITE, csr_pkg::CSR_MIP, '0, 2'b11, 5'b00000,
        '0, '0, '0, 1'b0, 1'b0, epc_v, tvec_v);
add_row("rd_mip", csr_pkg::OP_READ, csr_pkg::CSR_MIP, '0, 2'b00, 5'b00000,
        '0, '0, 64'h880, 1'b0, 1'b0, epc_v, tvec_v);

// ---------------------------------------------------------------------------
// set and clear
// ---------------------------------------------------------------------------
add_row("set_scr", csr_pkg::OP_SET, csr_pkg::CSR_MSCRATCH, 64'hf0, 2'b00, 5'b00000,
        '0, '0, scr_v, 1'b0, 1'b0, epc_v, tvec_v);
add_row("clr_scr", csr_pkg::OP_CLEAR, csr_pkg::CSR_MSCRATCH, 64'h0f, 2'b00, 5'b00000,
        '0, '0, scr_v | 64'hf0, 1'b0, 1'b0, epc_v, tvec_v);
add_row("rd_scr", csr_pkg::OP_READ, csr_pkg::CSR_MSCRATCH, '0, 2'b00, 5'b00000,
        '0, '0, scr_s, 1'b0, 1'b0, epc_v, tvec_v);
// no access and unknown addresses read zero
add_row("none_scr", csr_pkg::OP_NONE, csr_pkg::CSR_MSCRATCH, '0, 2'b00, 5'b00000,
        '0, '0, '0, 1'b0, 1'b0, epc_v, tvec_v);
add_row("rd_unimpl", csr_pkg::OP_READ, 12'h7c0, '0, 2'b00, 5'b00000,
        '0, '0, '0, 1'b0, 1'b0, epc_v, tvec_v);

// ---------------------------------------------------------------------------
// exceptions with all flags at once so illegal wins and the write is dropped
// ---------------------------------------------------------------------------
add_row("exc_multi", csr_pkg::OP_WRITE, csr_pkg::CSR_MTVAL, 64'h1234, 2'b00, 5'b11111,
        64'h8000_0100, 64'h55, '0, 1'b1, 1'b0, 64'h8000_0100, tvec_v);
add_row("rd_tval_ill", csr_pkg::OP_READ, csr_pkg::CSR_MTVAL, '0, 2'b00, 5'b00000,
        '0, '0, '0, 1'b0, 1'b0, 64'h8000_0100, tvec_v);
add_row("rd_cause_ill", csr_pkg::OP_READ, csr_pkg::CSR_MCAUSE, '0, 2'b00, 5'b00000,
        '0, '0, 64'h2, 1'b0, 1'b0, 64'h8000_0100, tvec_v);
add_row("set_mie", csr_pkg::OP_SET, csr_pkg::CSR_MIE, 64'h880, 2'b00, 5'b00000,
        '0, '0, '0, 1'b0, 1'b0, 64'h8000_0100, tvec_v);
add_row("clr_mie", csr_pkg::OP_CLEAR, csr_pkg::CSR_MIE, 64'h800, 2'b00, 5'b00000,
        '0, '0, 64'h880, 1'b0, 1'b0, 64'h8000_0100, tvec_v);
// load beats store and the faulting address lands in mtval
add_row("exc_ld", csr_pkg::OP_READ, csr_pkg::CSR_MIE, '0, 2'b00, 5'b00011,
        64'h8000_0200, 64'h1003, 64'h80, 1'b1, 1'b0, 64'h8000_0200, tvec_v);
add_row("rd_cause_ld", csr_pkg::OP_READ, csr_pkg::CSR_MCAUSE, '0, 2'b00, 5'b00000,
        '0, '0, 64'h4, 1'b0, 1'b0, 64'h8000_0200, tvec_v);
add_row("rd_tval_ld", csr_pkg::OP_READ, csr_pkg::CSR_MTVAL, '0, 2'b00, 5'b00000,
        '0, '0, 64'h1003, 1'b0, 1'b0, 64'h8000_0200, tvec_v);

// ---------------------------------------------------------------------------
// interrupts
// ---------------------------------------------------------------------------
add_row("tmr_idle", csr_pkg::OP_READ, csr_pkg::CSR_MSTATUS, '0, 2'b01, 5'b00000,
        '0, '0, 64'h1800, 1'b0, 1'b0, 64'h8000_0200, tvec_v);
// pending and enabled but global mie still low
add_row("tmr_masked", csr_pkg::OP_SET, csr_pkg::CSR_MSTATUS, 64'h8, 2'b01, 5'b00000,
        '0, '0, 64'h1800, 1'b0, 1'b0, 64'h8000_0200, tvec_v);
add_row("tmr_trap", csr_pkg::OP_READ, csr_pkg::CSR_MCAUSE, '0, 2'b01, 5'b00000,
        64'h8000_0400, '0, 64'h4, 1'b1, 1'b0, 64'h8000_0400, tvec_v);
add_row("rd_cause_tmr", csr_pkg::OP_READ, csr_pkg::CSR_MCAUSE, '0, 2'b00, 5'b00000,
        '0, '0, 64'h8000_0000_0000_0007, 1'b0, 1'b0, 64'h8000_0400, tvec_v);
add_row("set_meie", csr_pkg::OP_SET, csr_pkg::CSR_MIE, 64'h800, 2'b11, 5'b00000,
        '0, '0, 64'h80, 1'b0, 1'b0, 64'h8000_0400, tvec_v);
// mret brings mie back from mpie
add_row("mret", csr_pkg::OP_MRET, csr_pkg::CSR_MSTATUS, '0, 2'b11, 5'b00000,
        '0, '0, '0, 1'b0, 1'b1, 64'h8000_0400, tvec_v);
add_row("ext_trap", csr_pkg::OP_READ, csr_pkg::CSR_MSTATUS, '0, 2'b11, 5'b00000,
        64'h8000_0500, '0, 64'h1888, 1'b1, 1'b0, 64'h8000_0500, tvec_v);
add_row("rd_cause_ext", csr_pkg::OP_READ, csr_pkg::CSR_MCAUSE, '0, 2'b00, 5'b00000,
        '0, '0, 64'h8000_0000_0000_000b, 1'b0, 1'b0, 64'h8000_0500, tvec_v);

// trap in the same cycle as mret wins
add_row("mret_trap", csr_pkg::OP_MRET, csr_pkg::CSR_MSTATUS, '0, 2'b00, 5'b10000,
        64'h8000_0600, '0, '0, 1'b1, 1'b0, 64'h8000_0600, tvec_v);
add_row("rd_mstatus", csr_pkg::OP_READ, csr_pkg::CSR_MSTATUS, '0, 2'b00, 5'b00000,
        '0, '0, 64'h1800, 1'b0, 1'b0, 64'h8000_0600, tvec_v);

// ==== test/tb_csr.sv ====
module tb_csr;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int XLEN = 64;
    // rv64 with a c i m and mxl 2 in the top bits
    localparam logic [63:0] MISA_EXP = 64'h8000_0000_0000_1105;

    // one table row with the name kept apart
    typedef struct packed {
        csr_pkg::csr_op_e   op;
        csr_pkg::csr_addr_t addr;
        logic [63:0]        wdata;
        logic [1:0]         irq;
        logic [4:0]         exc;
        logic [63:0]        pc;
        logic [63:0]        alu;
        logic [63:0]        exp_rdata;
        logic               exp_taken;
        logic               exp_return;
        logic [63:0]        exp_epc;
        logic [63:0]        exp_tvec;
    } vec_t;

    logic               clk;
    logic               rst;
    csr_pkg::csr_addr_t csr_addr;
    csr_pkg::csr_op_e   csr_op;
    logic [XLEN-1:0]    wdata;
    logic               ext_int;
    logic               timer_int;
    logic               illegal;
    logic               ecall_m;
    logic               inst_mis;
    logic               load_mis;
    logic               store_mis;
    logic [XLEN-1:0]    pc;
    logic [XLEN-1:0]    alu_addr;
    logic [XLEN-1:0]    rdata;
    logic [XLEN-1:0]    ret_addr;
    logic [XLEN-1:0]    trap_addr;
    logic               trap_taken;
    logic               trap_return;

    vec_t  rows[$];
    string names[$];
    int    errors;
    int    checks;

    // random data and the values the masking rules leave
    logic [63:0] scr_v;
    logic [63:0] scr_s;
    logic [63:0] epc_raw;
    logic [63:0] epc_v;
    logic [63:0] tvec_raw;
    logic [63:0] tvec_v;

    riscv_csr_top #(.XLEN(XLEN)) u_dut (
        .i_riscv_csr_clk                   (clk),
        .i_riscv_csr_rst                   (rst),
        .i_riscv_csr_address               (csr_addr),
        .i_riscv_csr_op                    (csr_op),
        .i_riscv_csr_wdata                 (wdata),
        .i_riscv_csr_external_int          (ext_int),
        .i_riscv_csr_timer_int             (timer_int),
        .i_riscv_csr_illegal_inst          (illegal),
        .i_riscv_csr_ecall_m               (ecall_m),
        .i_riscv_csr_inst_addr_misaligned  (inst_mis),
        .i_riscv_csr_load_addr_misaligned  (load_mis),
        .i_riscv_csr_store_addr_misaligned (store_mis),
        .i_riscv_csr_pc                    (pc),
        .i_riscv_csr_alu_addr              (alu_addr),
        .o_riscv_csr_rdata                 (rdata),
        .o_riscv_csr_return_address        (ret_addr),
        .o_riscv_csr_trap_address          (trap_addr),
        .o_riscv_csr_trap_taken            (trap_taken),
        .o_riscv_csr_trap_return           (trap_return)
    );

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // table helpers
    // ------------------------------------------------------------------------
    task automatic add_row(
        input string              name,
        input csr_pkg::csr_op_e   op,
        input csr_pkg::csr_addr_t addr,
        input logic [63:0]        row_wdata,
        input logic [1:0]         irq,
        input logic [4:0]         exc,
        input logic [63:0]        row_pc,
        input logic [63:0]        alu,
        input logic [63:0]        exp_rdata,
        input logic               exp_taken,
        input logic               exp_return,
        input logic [63:0]        exp_epc,
        input logic [63:0]        exp_tvec
    );
        vec_t v;
        v.op         = op;
        v.addr       = addr;
        v.wdata      = row_wdata;
        v.irq        = irq;
        v.exc        = exc;
        v.pc         = row_pc;
        v.alu        = alu;
        v.exp_rdata  = exp_rdata;
        v.exp_taken  = exp_taken;
        v.exp_return = exp_return;
        v.exp_epc    = exp_epc;
        v.exp_tvec   = exp_tvec;
        rows.push_back(v);
        names.push_back(name);
    endtask

    task automatic load_table();
        `include "csr_vectors.svh"
    endtask

    // exc order is illegal, inst, ecall, load, store
    task automatic drive_row(input vec_t v);
        csr_op    = v.op;
        csr_addr  = v.addr;
        wdata     = v.wdata;
        pc        = v.pc;
        alu_addr  = v.alu;
        {ext_int, timer_int} = v.irq;
        {illegal, inst_mis, ecall_m, load_mis, store_mis} = v.exc;
    endtask

    task automatic compare(input string name, input string what,
                           input logic [63:0] expected, input logic [63:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s %s expected 0x%016h actual 0x%016h",
                     name, what, expected, actual);
        end
    endtask

    // registered outputs seen one cycle after the row
    task automatic check_registered(input int idx);
        compare(names[idx], "trap_taken", 64'(rows[idx].exp_taken), 64'(trap_taken));
        compare(names[idx], "trap_return", 64'(rows[idx].exp_return), 64'(trap_return));
        compare(names[idx], "return_address", rows[idx].exp_epc, ret_addr);
        compare(names[idx], "trap_address", rows[idx].exp_tvec, trap_addr);
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------
    initial begin
        int seed;
        seed      = 38;
        errors    = 0;
        checks    = 0;
        rst       = 1'b1;
        csr_addr  = '0;
        csr_op    = csr_pkg::OP_NONE;
        wdata     = '0;
        ext_int   = 1'b0;
        timer_int = 1'b0;
        illegal   = 1'b0;
        ecall_m   = 1'b0;
        inst_mis  = 1'b0;
        load_mis  = 1'b0;
        store_mis = 1'b0;
        pc        = '0;
        alu_addr  = '0;

        void'($urandom(seed));
        scr_v    = {$urandom, $urandom};
        // low bits forced on so the masks have work to do
        epc_raw  = {$urandom, $urandom} | 64'h1;
        tvec_raw = {$urandom, $urandom} | 64'hff;
        scr_s    = (scr_v | 64'hf0) & ~64'h0f;
        epc_v    = epc_raw & ~64'h1;
        // vectored mode keeps bit 0 and reads bits 7 to 1 as zero
        tvec_v   = tvec_raw & ~64'hfe;
        load_table();

        repeat (4) @(posedge clk);
        #10;
        rst = 1'b0;

        for (int i = 0; i < rows.size(); i++) begin
            if (i > 0) begin
                check_registered(i - 1);
            end
            drive_row(rows[i]);
            // read data settles well before the next edge
            #80;
            compare(names[i], "rdata", rows[i].exp_rdata, rdata);
            @(posedge clk);
            #10;
        end
        check_registered(rows.size() - 1);

        $display("tests done: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+test
rtl/csr_pkg.sv
rtl/trap_pkg.sv
rtl/csr_op_decode.sv
rtl/trap_arbiter.sv
rtl/csr_regs.sv
rtl/csr_read_mux.sv
rtl/riscv_csr_top.sv
test/tb_csr.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = tb_csr
FILELIST  = sources.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'PASS: all tests'

clean:
	rm -rf $(OBJ_DIR)
